// File: mem_stage.f
hw/mem_pkg.sv
hw/mem_access.sv
hw/addr_trans_check.sv
hw/axi_lite_master.sv
hw/mem_wb_reg.sv
hw/mem_stage_top.sv
bench/axi_lite_mem_model.sv
bench/mem_stage_tb.sv

// File: bench/mem_stage_vectors.txt
# op addr reg2 waddr excp | csr plv da pg dmw0 dmw1 | tlb found v d plv
# then expected wreg wdata excp_vec, all hex; wdata is ignored when excp_vec is nonzero
00 00000000 00000000 01 0 0 1 0 00000000 00000000 1 1 1 3 0 00000000 00
22 00000100 8765f0a1 02 0 0 1 0 00000000 00000000 1 1 1 3 0 00000000 00
10 00000100 00000000 03 0 0 1 0 00000000 00000000 1 1 1 3 1 ffffffa1 00
10 00000101 00000000 04 0 0 1 0 00000000 00000000 1 1 1 3 1 fffffff0 00
11 00000102 00000000 05 0 0 1 0 00000000 00000000 1 1 1 3 1 00000065 00
11 00000103 00000000 06 0 0 1 0 00000000 00000000 1 1 1 3 1 00000087 00
12 00000100 00000000 07 0 0 1 0 00000000 00000000 1 1 1 3 1 fffff0a1 00
13 00000102 00000000 08 0 0 1 0 00000000 00000000 1 1 1 3 1 00008765 00
12 00000102 00000000 09 0 0 1 0 00000000 00000000 1 1 1 3 1 ffff8765 00
22 00000104 11223344 0a 0 0 1 0 00000000 00000000 1 1 1 3 0 00000000 00
20 00000105 aaaaaa9c 0b 0 0 1 0 00000000 00000000 1 1 1 3 0 00000000 00
21 00000106 5555e7d2 0c 0 0 1 0 00000000 00000000 1 1 1 3 0 00000000 00
14 00000104 00000000 0d 0 0 1 0 00000000 00000000 1 1 1 3 1 e7d29c44 00
10 00000105 00000000 0e 0 0 1 0 00000000 00000000 1 1 1 3 1 ffffff9c 00
13 00000106 00000000 0f 0 0 1 0 00000000 00000000 1 1 1 3 1 0000e7d2 00
11 00000104 00000000 10 0 0 1 0 00000000 00000000 1 1 1 3 1 00000044 00
21 00000104 00007f01 11 0 0 1 0 00000000 00000000 1 1 1 3 0 00000000 00
22 00000108 cafe0001 12 0 0 1 0 00000000 00000000 1 1 1 3 0 00000000 00
30 00000108 00000000 13 0 0 1 0 00000000 00000000 1 1 1 3 0 cafe0001 00
31 00000108 0badf00d 14 0 0 1 0 00000000 00000000 1 1 1 3 1 00000001 00
31 00000108 77777777 15 0 0 1 0 00000000 00000000 1 1 1 3 1 00000000 00
14 00000108 00000000 16 0 0 1 0 00000000 00000000 1 1 1 3 1 0badf00d 00
12 00000101 00000000 17 0 0 1 0 00000000 00000000 1 1 1 3 0 00000000 02
22 00000102 deadbeef 18 0 0 1 0 00000000 00000000 1 1 1 3 0 00000000 02
14 00000100 00000000 19 0 0 1 0 00000000 00000000 1 1 1 3 1 8765f0a1 00
14 00000100 00000000 1a 0 3 0 1 00000000 00000000 0 0 0 3 0 00000000 04
14 00000100 00000000 1b 0 3 0 1 00000000 00000000 1 0 0 3 0 00000000 40
22 00000100 12345678 1c 0 3 0 1 00000000 00000000 1 0 1 3 0 00000000 20
14 00000100 00000000 1d 0 3 0 1 00000000 00000000 1 1 1 0 0 00000000 10
22 00000100 12345678 1e 0 3 0 1 00000000 00000000 1 1 0 3 0 00000000 08
14 a0000100 00000000 1f 0 3 0 1 a0000008 00000000 0 0 0 3 1 8765f0a1 00
13 20000102 00000000 00 0 0 0 1 00000000 20000001 1 0 0 3 1 00008765 00
14 00000104 00000000 01 0 3 1 0 00000000 00000000 0 0 0 3 1 e7d27f01 00
20 a000010c 000000b7 02 0 3 0 1 a0000008 00000000 1 1 0 3 0 00000000 00
11 0000010c 00000000 03 0 0 1 0 00000000 00000000 1 1 1 3 1 000000b7 00
14 00000100 00000000 04 1 0 1 0 00000000 00000000 1 1 1 3 0 00000000 01
22 00000108 99999999 05 1 0 1 0 00000000 00000000 1 1 1 3 0 00000000 01
14 00000108 00000000 06 0 0 1 0 00000000 00000000 1 1 1 3 1 0badf00d 00

// File: bench/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb import mem_pkg::*; ();

    localparam int PERIOD_NS         = 100;
    localparam int DRIVE_NS          = 10;
    localparam int RESET_CYCLES      = 16;
    localparam int NUM_VECTORS       = 38;
    localparam int CYCLES_PER_VECTOR = 50;
    localparam int NUM_FIELDS        = 17;
    localparam int WATCHDOG_NS       =
        (NUM_VECTORS * CYCLES_PER_VECTOR + RESET_CYCLES) * PERIOD_NS;

    logic      clk;
    logic      reset_i;
    logic      in_valid_i;
    logic      in_ready_o;
    aluop_t    aluop_i;
    word_t     mem_addr_i;
    word_t     reg2_i;
    logic      wreg_i;
    reg_addr_t waddr_i;
    word_t     wdata_i;
    logic      excp_i;
    plv_t      csr_plv_i;
    logic      csr_da_i;
    logic      csr_pg_i;
    word_t     csr_dmw0_i;
    word_t     csr_dmw1_i;
    logic      tlb_found_i;
    logic      tlb_v_i;
    logic      tlb_d_i;
    plv_t      tlb_plv_i;
    logic      wb_valid_o;
    logic      wb_wreg_o;
    reg_addr_t wb_waddr_o;
    word_t     wb_wdata_o;
    logic      wb_excp_o;
    excp_vec_t wb_excp_vec_o;
    word_t     awaddr_o;
    logic      awvalid_o;
    logic      awready_i;
    word_t     wdata_o;
    strb_t     wstrb_o;
    logic      wvalid_o;
    logic      wready_i;
    logic      bvalid_i;
    logic      bready_o;
    word_t     rdata_i;
    logic      rvalid_i;
    logic      rready_o;
    word_t     araddr_o;
    logic      arvalid_o;
    logic      arready_i;

    // one vector line as read from the file
    logic [31:0] fld [NUM_FIELDS];
    int          error_count;
    int          tests_run;
    int          tests_failed;

    mem_stage_top i_dut (.*);

    axi_lite_mem_model i_mem_model (
        .clk       (clk),
        .reset_i   (reset_i),
        .awaddr_i  (awaddr_o),
        .awvalid_i (awvalid_o),
        .awready_o (awready_i),
        .wdata_i   (wdata_o),
        .wstrb_i   (wstrb_o),
        .wvalid_i  (wvalid_o),
        .wready_o  (wready_i),
        .bvalid_o  (bvalid_i),
        .bready_i  (bready_o),
        .rdata_o   (rdata_i),
        .rvalid_o  (rvalid_i),
        .rready_i  (rready_o),
        .araddr_i  (araddr_o),
        .arvalid_i (arvalid_o),
        .arready_o (arready_i)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the stage did not finish the vectors in %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0t ns: %s is %08h, expected %08h",
                     $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic run_vector();
        int errors_before;
        errors_before = error_count;
        while (in_ready_o !== 1'b1) begin
            @(posedge clk);
            #DRIVE_NS;
        end
        aluop_i     = fld[0][7:0];
        mem_addr_i  = fld[1];
        reg2_i      = fld[2];
        waddr_i     = fld[3][4:0];
        excp_i      = fld[4][0];
        csr_plv_i   = fld[5][1:0];
        csr_da_i    = fld[6][0];
        csr_pg_i    = fld[7][0];
        csr_dmw0_i  = fld[8];
        csr_dmw1_i  = fld[9];
        tlb_found_i = fld[10][0];
        tlb_v_i     = fld[11][0];
        tlb_d_i     = fld[12][0];
        tlb_plv_i   = fld[13][1:0];
        // memory ops decide wreg themselves
        wreg_i      = (fld[0][7:0] != OP_NOP);
        in_valid_i  = 1'b1;
        @(posedge clk);
        #DRIVE_NS;
        in_valid_i = 1'b0;
        // fields stay put until the result is back
        while (wb_valid_o !== 1'b1) begin
            @(posedge clk);
            #DRIVE_NS;
        end
        compare_value("wreg", wb_wreg_o, fld[14]);
        compare_value("waddr", wb_waddr_o, fld[3]);
        compare_value("exception vector", wb_excp_vec_o, fld[16]);
        compare_value("exception flag", wb_excp_o, fld[16] != 0);
        // data is only defined for an op without exception
        if (fld[16] == 0) begin
            compare_value("wdata", wb_wdata_o, fld[15]);
        end
        tests_run++;
        if (error_count != errors_before) begin
            tests_failed++;
        end
        $display("test %0d: op %02h at %08h %s", tests_run, fld[0][7:0], fld[1],
                 (error_count == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset_i      = 1'b1;
        in_valid_i   = 1'b0;
        aluop_i      = OP_NOP;
        mem_addr_i   = '0;
        reg2_i       = '0;
        wreg_i       = 1'b0;
        waddr_i      = '0;
        wdata_i      = '0;
        excp_i       = 1'b0;
        csr_plv_i    = '0;
        csr_da_i     = 1'b1;
        csr_pg_i     = 1'b0;
        csr_dmw0_i   = '0;
        csr_dmw1_i   = '0;
        tlb_found_i  = 1'b0;
        tlb_v_i      = 1'b0;
        tlb_d_i      = 1'b0;
        tlb_plv_i    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_NS;
        reset_i = 1'b0;

        fd = $fopen("bench/mem_stage_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/mem_stage_vectors.txt");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                                fld[6], fld[7], fld[8], fld[9], fld[10], fld[11],
                                fld[12], fld[13], fld[14], fld[15], fld[16]);
                    if (n == NUM_FIELDS) begin
                        run_vector();
                    end
                end
            end
            $fclose(fd);
        end

        if (tests_run != NUM_VECTORS) begin
            $display("only %0d of %0d vectors were run", tests_run, NUM_VECTORS);
            error_count++;
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: bench/axi_lite_mem_model.sv
`timescale 1ns/1ps

module axi_lite_mem_model import mem_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,

    input  word_t awaddr_i,
    input  logic  awvalid_i,
    output logic  awready_o,
    input  word_t wdata_i,
    input  strb_t wstrb_i,
    input  logic  wvalid_i,
    output logic  wready_o,
    output logic  bvalid_o,
    input  logic  bready_i,
    output word_t rdata_o,
    output logic  rvalid_o,
    input  logic  rready_i,
    input  word_t araddr_i,
    input  logic  arvalid_i,
    output logic  arready_o
);

    localparam int          MEM_WORDS = 256;
    localparam logic [31:0] RAND_SEED = 32'h6248;

    word_t       mem [MEM_WORDS];
    logic [31:0] rnd_q;
    logic        aw_got;
    logic        w_got;
    logic        ar_got;
    word_t       aw_addr;
    word_t       ar_addr;
    word_t       w_data;
    strb_t       w_strb;

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t merge_strobed(input word_t old_word, input word_t new_word,
                                            input strb_t strb);
        word_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    initial begin
        // fill tied to the word index
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {8'h5a, i[7:0], ~i[7:0], i[7:0]};
        end
        awready_o = 1'b0;
        wready_o  = 1'b0;
        arready_o = 1'b0;
        bvalid_o  = 1'b0;
        rvalid_o  = 1'b0;
        rdata_o   = '0;
    end

    always @(posedge clk) begin
        if (reset_i) begin
            rnd_q     <= RAND_SEED;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            arready_o <= 1'b0;
            bvalid_o  <= 1'b0;
            rvalid_o  <= 1'b0;
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
            ar_got    <= 1'b0;
        end else begin
            rnd_q     <= next_rand(rnd_q);
            awready_o <= rnd_q[0] & ~aw_got;
            wready_o  <= rnd_q[1] & ~w_got;
            arready_o <= rnd_q[2] & ~ar_got & ~rvalid_o;

            if (awvalid_i && awready_o) begin
                aw_got    <= 1'b1;
                aw_addr   <= awaddr_i;
                awready_o <= 1'b0;
            end
            if (wvalid_i && wready_o) begin
                w_got    <= 1'b1;
                w_data   <= wdata_i;
                w_strb   <= wstrb_i;
                wready_o <= 1'b0;
            end
            // write lands when the response is raised
            if (aw_got && w_got && !bvalid_o && rnd_q[3]) begin
                mem[aw_addr[9:2]] <= merge_strobed(mem[aw_addr[9:2]], w_data, w_strb);
                bvalid_o <= 1'b1;
            end
            if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
                aw_got   <= 1'b0;
                w_got    <= 1'b0;
            end

            if (arvalid_i && arready_o) begin
                ar_got    <= 1'b1;
                ar_addr   <= araddr_i;
                arready_o <= 1'b0;
            end
            if (ar_got && !rvalid_o && rnd_q[4]) begin
                rvalid_o <= 1'b1;
                rdata_o  <= mem[ar_addr[9:2]];
                ar_got   <= 1'b0;
            end
            if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

endmodule

// File: hw/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top import mem_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,

    input  logic      in_valid_i,
    output logic      in_ready_o,
    input  aluop_t    aluop_i,
    input  word_t     mem_addr_i,
    input  word_t     reg2_i,
    input  logic      wreg_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  logic      excp_i,

    input  plv_t      csr_plv_i,
    input  logic      csr_da_i,
    input  logic      csr_pg_i,
    input  word_t     csr_dmw0_i,
    input  word_t     csr_dmw1_i,

    input  logic      tlb_found_i,
    input  logic      tlb_v_i,
    input  logic      tlb_d_i,
    input  plv_t      tlb_plv_i,

    output logic      wb_valid_o,
    output logic      wb_wreg_o,
    output reg_addr_t wb_waddr_o,
    output word_t     wb_wdata_o,
    output logic      wb_excp_o,
    output excp_vec_t wb_excp_vec_o,

    output word_t     awaddr_o,
    output logic      awvalid_o,
    input  logic      awready_i,
    output word_t     wdata_o,
    output strb_t     wstrb_o,
    output logic      wvalid_o,
    input  logic      wready_i,
    input  logic      bvalid_i,
    output logic      bready_o,
    input  word_t     rdata_i,
    input  logic      rvalid_i,
    output logic      rready_o,
    output word_t     araddr_o,
    output logic      arvalid_o,
    input  logic      arready_i
);

    logic      busy_q;
    logic      accept;
    logic      capture;
    logic      req_valid;
    logic      req_we;
    word_t     req_addr;
    word_t     req_wdata;
    strb_t     req_strb;
    logic      mem_op;
    logic      is_load;
    logic      res_wreg;
    reg_addr_t res_waddr;
    word_t     res_wdata;
    excp_vec_t excp_vec;
    excp_vec_t trans_excp;
    logic      ll_we;
    logic      ll_value;
    logic      llbit;
    logic      mst_done;
    word_t     mst_rdata;

    assign in_ready_o = ~busy_q;
    assign accept     = in_valid_i & in_ready_o;

    // no bus access means the result is ready right away
    assign capture = (accept & ~req_valid) | mst_done;

    assign is_load = mem_op & ~req_we;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q <= 1'b0;
        end else if (accept && req_valid) begin
            busy_q <= 1'b1;
        end else if (mst_done) begin
            busy_q <= 1'b0;
        end
    end

    mem_access i_mem_access (
        .aluop_i      (aluop_i),
        .mem_addr_i   (mem_addr_i),
        .reg2_i       (reg2_i),
        .wreg_i       (wreg_i),
        .waddr_i      (waddr_i),
        .wdata_i      (wdata_i),
        .excp_i       (excp_i),
        .llbit_i      (llbit),
        .trans_excp_i (trans_excp),
        .rdata_i      (mst_rdata),
        .req_valid_o  (req_valid),
        .req_we_o     (req_we),
        .req_addr_o   (req_addr),
        .req_wdata_o  (req_wdata),
        .req_strb_o   (req_strb),
        .mem_op_o     (mem_op),
        .wreg_o       (res_wreg),
        .waddr_o      (res_waddr),
        .res_wdata_o  (res_wdata),
        .excp_vec_o   (excp_vec),
        .ll_we_o      (ll_we),
        .ll_value_o   (ll_value)
    );

    addr_trans_check i_addr_trans_check (
        .mem_op_i     (mem_op),
        .is_load_i    (is_load),
        .csr_plv_i    (csr_plv_i),
        .csr_da_i     (csr_da_i),
        .csr_pg_i     (csr_pg_i),
        .csr_dmw0_i   (csr_dmw0_i),
        .csr_dmw1_i   (csr_dmw1_i),
        .vaddr_i      (mem_addr_i),
        .tlb_found_i  (tlb_found_i),
        .tlb_v_i      (tlb_v_i),
        .tlb_d_i      (tlb_d_i),
        .tlb_plv_i    (tlb_plv_i),
        .trans_excp_o (trans_excp)
    );

    axi_lite_master i_axi_lite_master (
        .clk         (clk),
        .reset_i     (reset_i),
        .req_valid_i (accept & req_valid),
        .req_we_i    (req_we),
        .req_addr_i  (req_addr),
        .req_wdata_i (req_wdata),
        .req_strb_i  (req_strb),
        .done_o      (mst_done),
        .rdata_o     (mst_rdata),
        .awaddr_o    (awaddr_o),
        .awvalid_o   (awvalid_o),
        .awready_i   (awready_i),
        .wdata_o     (wdata_o),
        .wstrb_o     (wstrb_o),
        .wvalid_o    (wvalid_o),
        .wready_i    (wready_i),
        .bvalid_i    (bvalid_i),
        .bready_o    (bready_o),
        .rdata_i     (rdata_i),
        .rvalid_i    (rvalid_i),
        .rready_o    (rready_o),
        .araddr_o    (araddr_o),
        .arvalid_o   (arvalid_o),
        .arready_i   (arready_i)
    );

    mem_wb_reg i_mem_wb_reg (
        .clk           (clk),
        .reset_i       (reset_i),
        .capture_i     (capture),
        .wreg_i        (res_wreg),
        .waddr_i       (res_waddr),
        .wdata_i       (res_wdata),
        .excp_vec_i    (excp_vec),
        .ll_we_i       (ll_we),
        .ll_value_i    (ll_value),
        .llbit_o       (llbit),
        .wb_valid_o    (wb_valid_o),
        .wb_wreg_o     (wb_wreg_o),
        .wb_waddr_o    (wb_waddr_o),
        .wb_wdata_o    (wb_wdata_o),
        .wb_excp_o     (wb_excp_o),
        .wb_excp_vec_o (wb_excp_vec_o)
    );

endmodule

// File: hw/mem_wb_reg.sv
`timescale 1ns/1ps

module mem_wb_reg import mem_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      capture_i,
    input  logic      wreg_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  excp_vec_t excp_vec_i,
    input  logic      ll_we_i,
    input  logic      ll_value_i,

    output logic      llbit_o,
    output logic      wb_valid_o,
    output logic      wb_wreg_o,
    output reg_addr_t wb_waddr_o,
    output word_t     wb_wdata_o,
    output logic      wb_excp_o,
    output excp_vec_t wb_excp_vec_o
);

    logic any_excp;

    assign any_excp = |excp_vec_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid_o <= 1'b0;
            wb_wreg_o  <= 1'b0;
            wb_excp_o  <= 1'b0;
            llbit_o    <= 1'b0;
        end else begin
            wb_valid_o <= capture_i;
            if (capture_i) begin
                // an excepting op never writes the register file
                wb_wreg_o <= wreg_i & ~any_excp;
                wb_excp_o <= any_excp;
                if (ll_we_i) begin
                    llbit_o <= ll_value_i;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture_i) begin
            wb_waddr_o    <= waddr_i;
            wb_wdata_o    <= wdata_i;
            wb_excp_vec_o <= excp_vec_i;
        end
    end

endmodule

// File: hw/axi_lite_master.sv
`timescale 1ns/1ps

module axi_lite_master import mem_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,

    input  logic  req_valid_i,
    input  logic  req_we_i,
    input  word_t req_addr_i,
    input  word_t req_wdata_i,
    input  strb_t req_strb_i,
    output logic  done_o,
    output word_t rdata_o,

    output word_t awaddr_o,
    output logic  awvalid_o,
    input  logic  awready_i,
    output word_t wdata_o,
    output strb_t wstrb_o,
    output logic  wvalid_o,
    input  logic  wready_i,
    input  logic  bvalid_i,
    output logic  bready_o,
    input  word_t rdata_i,
    input  logic  rvalid_i,
    output logic  rready_o,
    output word_t araddr_o,
    output logic  arvalid_o,
    input  logic  arready_i
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RADDR,
        S_RDATA,
        S_WADDR,
        S_WRESP
    } state_t;

    state_t state_q;
    logic   aw_done_q;
    logic   w_done_q;
    logic   done_q;
    logic   aw_hs;
    logic   w_hs;
    word_t  addr_q;
    word_t  wdata_q;
    strb_t  strb_q;
    word_t  rdata_q;

    assign awvalid_o = (state_q == S_WADDR) & ~aw_done_q;
    assign wvalid_o  = (state_q == S_WADDR) & ~w_done_q;
    assign arvalid_o = (state_q == S_RADDR);
    assign rready_o  = (state_q == S_RDATA);
    assign bready_o  = (state_q == S_WRESP);

    assign awaddr_o = addr_q;
    assign araddr_o = addr_q;
    assign wdata_o  = wdata_q;
    assign wstrb_o  = strb_q;

    assign aw_hs = awvalid_o & awready_i;
    assign w_hs  = wvalid_o & wready_i;

    assign done_o  = done_q;
    assign rdata_o = rdata_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= S_IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    // a new request waits until the last done has gone
                    if (req_valid_i && !done_q) begin
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                        state_q   <= req_we_i ? S_WADDR : S_RADDR;
                    end
                end
                S_RADDR: begin
                    if (arready_i) begin
                        state_q <= S_RDATA;
                    end
                end
                S_RDATA: begin
                    if (rvalid_i) begin
                        done_q  <= 1'b1;
                        state_q <= S_IDLE;
                    end
                end
                S_WADDR: begin
                    if (aw_hs) begin
                        aw_done_q <= 1'b1;
                    end
                    if (w_hs) begin
                        w_done_q <= 1'b1;
                    end
                    if ((aw_done_q | aw_hs) && (w_done_q | w_hs)) begin
                        state_q <= S_WRESP;
                    end
                end
                S_WRESP: begin
                    if (bvalid_i) begin
                        done_q  <= 1'b1;
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // request payload, held stable for the whole access
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && req_valid_i && !done_q) begin
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
            strb_q  <= req_strb_i;
        end
        if (rready_o && rvalid_i) begin
            rdata_q <= rdata_i;
        end
    end

endmodule

// File: hw/addr_trans_check.sv
`timescale 1ns/1ps

module addr_trans_check import mem_pkg::*; (
    input  logic      mem_op_i,
    input  logic      is_load_i,
    input  plv_t      csr_plv_i,
    input  logic      csr_da_i,
    input  logic      csr_pg_i,
    input  word_t     csr_dmw0_i,
    input  word_t     csr_dmw1_i,
    input  word_t     vaddr_i,
    input  logic      tlb_found_i,
    input  logic      tlb_v_i,
    input  logic      tlb_d_i,
    input  plv_t      tlb_plv_i,
    output excp_vec_t trans_excp_o
);

    logic dmw0_hit;
    logic dmw1_hit;
    logic pg_mode;
    logic trans_en;
    logic plv_ok;

    function automatic logic dmw_match(input word_t dmw, input plv_t plv, input word_t va);
        logic plv_en;
        plv_en = (dmw[DMW_PLV0] && plv == 2'd0) || (dmw[DMW_PLV3] && plv == 2'd3);
        return plv_en && (dmw[DMW_VSEG_HI:DMW_VSEG_LO] == va[31:29]);
    endfunction

    assign dmw0_hit = dmw_match(csr_dmw0_i, csr_plv_i, vaddr_i);
    assign dmw1_hit = dmw_match(csr_dmw1_i, csr_plv_i, vaddr_i);

    assign pg_mode  = ~csr_da_i & csr_pg_i;
    // page table lookup only when no window covers the address
    assign trans_en = mem_op_i & pg_mode & ~dmw0_hit & ~dmw1_hit;

    assign plv_ok = (csr_plv_i <= tlb_plv_i);

    always_comb begin
        trans_excp_o = '0;
        trans_excp_o[EXC_TLBR] = trans_en & ~tlb_found_i;
        trans_excp_o[EXC_PIL]  = trans_en & tlb_found_i & ~tlb_v_i & is_load_i;
        trans_excp_o[EXC_PIS]  = trans_en & tlb_found_i & ~tlb_v_i & ~is_load_i;
        trans_excp_o[EXC_PPI]  = trans_en & tlb_found_i & tlb_v_i & ~plv_ok;
        // store to a clean page
        trans_excp_o[EXC_PME]  = trans_en & tlb_found_i & tlb_v_i & plv_ok
                                 & ~is_load_i & ~tlb_d_i;
    end

endmodule

// File: hw/mem_access.sv
`timescale 1ns/1ps

module mem_access import mem_pkg::*; (
    input  aluop_t    aluop_i,
    input  word_t     mem_addr_i,
    input  word_t     reg2_i,
    input  logic      wreg_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  logic      excp_i,
    input  logic      llbit_i,
    input  excp_vec_t trans_excp_i,
    input  word_t     rdata_i,

    output logic      req_valid_o,
    output logic      req_we_o,
    output word_t     req_addr_o,
    output word_t     req_wdata_o,
    output strb_t     req_strb_o,
    output logic      mem_op_o,
    output logic      wreg_o,
    output reg_addr_t waddr_o,
    output word_t     res_wdata_o,
    output excp_vec_t excp_vec_o,
    output logic      ll_we_o,
    output logic      ll_value_o
);

    logic       is_load;
    logic       is_store;
    logic       is_half;
    logic       is_word;
    logic       is_ll;
    logic       is_sc;
    logic       misaligned;
    logic       any_excp;
    logic       sc_fail;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    assign is_load  = aluop_i inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W, OP_LL};
    assign is_store = aluop_i inside {OP_ST_B, OP_ST_H, OP_ST_W, OP_SC};
    assign is_half  = aluop_i inside {OP_LD_H, OP_LD_HU, OP_ST_H};
    assign is_word  = aluop_i inside {OP_LD_W, OP_ST_W, OP_LL, OP_SC};
    assign is_ll    = (aluop_i == OP_LL);
    assign is_sc    = (aluop_i == OP_SC);

    assign misaligned = (is_half & mem_addr_i[0]) | (is_word & (|mem_addr_i[1:0]));

    assign mem_op_o = is_load | is_store;
    // also tells the translation check a load from a store
    assign req_we_o = is_store;

    always_comb begin
        excp_vec_o = trans_excp_i;
        excp_vec_o[EXC_IN]  = trans_excp_i[EXC_IN] | excp_i;
        excp_vec_o[EXC_ALE] = trans_excp_i[EXC_ALE] | misaligned;
    end

    assign any_excp = |excp_vec_o;
    assign sc_fail  = is_sc & ~llbit_i;

    assign req_valid_o = mem_op_o & ~any_excp & ~sc_fail;
    assign req_addr_o  = {mem_addr_i[31:2], 2'b00};

    // LL sets the bit, a successful SC clears it
    assign ll_we_o    = (is_ll | (is_sc & llbit_i)) & ~any_excp;
    assign ll_value_o = is_ll;

    // lane strobe and replicated store data
    always_comb begin
        case (aluop_i)
            OP_ST_B: begin
                req_strb_o  = strb_t'(4'b0001 << mem_addr_i[1:0]);
                req_wdata_o = {4{reg2_i[7:0]}};
            end
            OP_ST_H: begin
                req_strb_o  = mem_addr_i[1] ? 4'b1100 : 4'b0011;
                req_wdata_o = {2{reg2_i[15:0]}};
            end
            default: begin
                req_strb_o  = 4'b1111;
                req_wdata_o = reg2_i;
            end
        endcase
    end

    always_comb begin
        case (mem_addr_i[1:0])
            2'b00:   ld_byte = rdata_i[7:0];
            2'b01:   ld_byte = rdata_i[15:8];
            2'b10:   ld_byte = rdata_i[23:16];
            default: ld_byte = rdata_i[31:24];
        endcase
    end

    assign ld_half = mem_addr_i[1] ? rdata_i[31:16] : rdata_i[15:0];

    assign waddr_o = waddr_i;

    // writeback value per operation
    always_comb begin
        wreg_o      = wreg_i;
        res_wdata_o = wdata_i;
        case (aluop_i)
            OP_LD_B: begin
                wreg_o      = 1'b1;
                res_wdata_o = {{24{ld_byte[7]}}, ld_byte};
            end
            OP_LD_BU: begin
                wreg_o      = 1'b1;
                res_wdata_o = {24'b0, ld_byte};
            end
            OP_LD_H: begin
                wreg_o      = 1'b1;
                res_wdata_o = {{16{ld_half[15]}}, ld_half};
            end
            OP_LD_HU: begin
                wreg_o      = 1'b1;
                res_wdata_o = {16'b0, ld_half};
            end
            OP_LD_W: begin
                wreg_o      = 1'b1;
                res_wdata_o = rdata_i;
            end
            OP_LL: begin
                wreg_o      = 1'b0;
                res_wdata_o = rdata_i;
            end
            OP_ST_B, OP_ST_H, OP_ST_W: begin
                wreg_o = 1'b0;
            end
            OP_SC: begin
                // 1 on success, 0 when the LL bit was lost
                wreg_o      = 1'b1;
                res_wdata_o = {31'b0, llbit_i};
            end
            default: begin
                wreg_o = wreg_i;
            end
        endcase
    end

endmodule

// File: hw/mem_pkg.sv
package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  plv_t;
    typedef logic [7:0]  aluop_t;

    // one bit per cause, see EXC_* positions
    typedef logic [6:0]  excp_vec_t;

    // operation codes from the execute stage
    localparam aluop_t OP_NOP   = 8'h00;
    localparam aluop_t OP_LD_B  = 8'h10;
    localparam aluop_t OP_LD_BU = 8'h11;
    localparam aluop_t OP_LD_H  = 8'h12;
    localparam aluop_t OP_LD_HU = 8'h13;
    localparam aluop_t OP_LD_W  = 8'h14;
    localparam aluop_t OP_ST_B  = 8'h20;
    localparam aluop_t OP_ST_H  = 8'h21;
    localparam aluop_t OP_ST_W  = 8'h22;
    localparam aluop_t OP_LL    = 8'h30;
    localparam aluop_t OP_SC    = 8'h31;

    // exception bit positions
    localparam int EXC_IN   = 0;
    localparam int EXC_ALE  = 1;
    localparam int EXC_TLBR = 2;
    localparam int EXC_PME  = 3;
    localparam int EXC_PPI  = 4;
    localparam int EXC_PIS  = 5;
    localparam int EXC_PIL  = 6;

    // field positions inside a DMW csr word
    localparam int DMW_PLV0    = 0;
    localparam int DMW_PLV3    = 3;
    localparam int DMW_VSEG_LO = 29;
    localparam int DMW_VSEG_HI = 31;

endpackage
